/* flist.f */
logic/preheat_pkg.sv
logic/preheat_cmd_if.sv
logic/preheat_axil_regs.sv
logic/preheat_ctrl.sv
logic/row_feeder.sv
logic/preheat_top.sv
verif/tb_preheat.sv

/* logic/preheat_axil_regs.sv */
//============================================================
// Preheat AXI4-Lite register block
// CTRL holds layer type and start, STATUS reports busy/done
//============================================================
`timescale 1ns/100ps

module preheat_axil_regs
    import preheat_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // AXI4-Lite slave
    input  logic [AXI_ADDR_W-1:0] s_awaddr_i,
    input  logic                  s_awvalid_i,
    output logic                  s_awready_o,
    input  logic [AXI_DATA_W-1:0] s_wdata_i,
    input  logic                  s_wvalid_i,
    output logic                  s_wready_o,
    output logic [1:0]            s_bresp_o,
    output logic                  s_bvalid_o,
    input  logic                  s_bready_i,
    input  logic [AXI_ADDR_W-1:0] s_araddr_i,
    input  logic                  s_arvalid_i,
    output logic                  s_arready_o,
    output logic [AXI_DATA_W-1:0] s_rdata_o,
    output logic [1:0]            s_rresp_o,
    output logic                  s_rvalid_o,
    input  logic                  s_rready_i,
    // Controller side
    output logic                  start_o,
    output layer_type_e           layer_type_o,
    input  logic                  busy_i,
    input  logic                  done_pulse_i
);

    logic                  aw_done_q;   // Write address taken, waiting for data
    logic                  w_done_q;    // Write data taken, waiting for address
    logic [AXI_ADDR_W-1:0] awaddr_q;
    logic [AXI_DATA_W-1:0] wdata_q;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  ar_hs;
    logic                  wr_fire;
    logic [AXI_ADDR_W-1:0] wr_addr;
    logic [AXI_DATA_W-1:0] wr_data;
    logic [AXI_DATA_W-1:0] rd_data;
    layer_type_e           layer_type_q;
    logic                  done_q;      // Sticky done flag

    //============================================================
    // Write channel
    //============================================================
    assign s_awready_o = !aw_done_q && !s_bvalid_o;
    assign s_wready_o  = !w_done_q && !s_bvalid_o;
    assign aw_hs       = s_awvalid_i && s_awready_o;
    assign w_hs        = s_wvalid_i && s_wready_o;

    // Commit once address and data are both in hand
    assign wr_fire = (aw_done_q || aw_hs) && (w_done_q || w_hs);
    assign wr_addr = aw_done_q ? awaddr_q : s_awaddr_i;
    assign wr_data = w_done_q ? wdata_q : s_wdata_i;
    assign s_bresp_o = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= s_awaddr_i;
        end
        if (w_hs) begin
            wdata_q <= s_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done_q    <= 1'b0;
            w_done_q     <= 1'b0;
            s_bvalid_o   <= 1'b0;
            start_o      <= 1'b0;
            layer_type_q <= POINTWISE;
            done_q       <= 1'b0;
        end else begin
            start_o <= 1'b0;                            // Pulse lasts one cycle
            if (wr_fire) begin
                aw_done_q  <= 1'b0;
                w_done_q   <= 1'b0;
                s_bvalid_o <= 1'b1;
                if (wr_addr == REG_CTRL_ADDR) begin
                    layer_type_q <= layer_type_e'(wr_data[2:1]);
                    start_o      <= wr_data[0];
                    if (wr_data[0]) begin
                        done_q <= 1'b0;                 // New run clears done
                    end
                end
            end else begin
                if (aw_hs) begin
                    aw_done_q <= 1'b1;
                end
                if (w_hs) begin
                    w_done_q <= 1'b1;
                end
            end
            if (s_bvalid_o && s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            if (done_pulse_i) begin
                done_q <= 1'b1;                         // Set wins over clear
            end
        end
    end

    //============================================================
    // Read channel
    //============================================================
    assign s_arready_o = !s_rvalid_o;
    assign ar_hs       = s_arvalid_i && s_arready_o;
    assign s_rresp_o   = RESP_OKAY;

    always_comb begin
        case (s_araddr_i)
            REG_CTRL_ADDR:   rd_data = {{(AXI_DATA_W-3){1'b0}}, layer_type_q, 1'b0};
            REG_STATUS_ADDR: rd_data = {{(AXI_DATA_W-2){1'b0}}, done_q, busy_i};
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s_rdata_o <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid_o <= 1'b0;
        end else if (ar_hs) begin
            s_rvalid_o <= 1'b1;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    assign layer_type_o = layer_type_q;

endmodule

/* logic/preheat_cmd_if.sv */
//============================================================
// Preheat command interface
// Load strobe, need mask and pop counts out, done mask back
//============================================================
`timescale 1ns/100ps

interface preheat_cmd_if
    import preheat_pkg::*;
#(
    parameter int NUM_ROWS = 32
) ();

    logic                            load;     // One-cycle load strobe
    logic [NUM_ROWS-1:0]             need;     // Rows that take part in preheat
    logic [NUM_ROWS-1:0][CNT_W-1:0]  pop_num;  // Pops per row, valid with load
    logic [NUM_ROWS-1:0]             done;     // Row has no pops left

    modport ctrl (
        output load,
        output need,
        output pop_num,
        input  done
    );

    modport feeder (
        input  load,
        input  need,
        input  pop_num,
        output done
    );

endinterface

/* logic/preheat_ctrl.sv */
//============================================================
// Preheat controller
// Loads per-row pop counts and waits for every row to finish
//============================================================
`timescale 1ns/100ps

module preheat_ctrl
    import preheat_pkg::*;
#(
    parameter int NUM_ROWS = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start_i,
    input  layer_type_e   layer_type_i,
    preheat_cmd_if.ctrl   ifmap_cmd,
    preheat_cmd_if.ctrl   ipsum_cmd,
    output logic          busy_o,
    output logic          preheat_done_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT,
        S_DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    int     ifmap_rows;
    int     ipsum_rows;

    //============================================================
    // State machine
    //============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_LOAD;
                end
            end
            S_LOAD: state_d = S_WAIT;                  // Feeders latch counts here
            S_WAIT: begin
                if (&ifmap_cmd.done && &ipsum_cmd.done) begin
                    state_d = S_DONE;
                end
            end
            S_DONE: state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    //============================================================
    // Need masks and pop counts
    //============================================================
    assign ifmap_rows = ifmap_active_rows(layer_type_i, NUM_ROWS);
    assign ipsum_rows = ipsum_active_rows(layer_type_i, NUM_ROWS);

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            ifmap_cmd.need[r]    = (r < ifmap_rows);
            ifmap_cmd.pop_num[r] = ifmap_pop_count(layer_type_i, r);
            ipsum_cmd.need[r]    = (r < ipsum_rows);
            ipsum_cmd.pop_num[r] = CNT_W'(1);          // One ipsum word per row
        end
    end

    assign ifmap_cmd.load = (state_q == S_LOAD);
    assign ipsum_cmd.load = (state_q == S_LOAD);

    assign busy_o         = (state_q != S_IDLE);
    assign preheat_done_o = (state_q == S_DONE);

endmodule

/* logic/preheat_pkg.sv */
//============================================================
// Preheat shared definitions
// Layer types, register map, payload types and pop-count rules
//============================================================
package preheat_pkg;

    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    localparam int CNT_W      = 5;               // Largest pop count is 30
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL_ADDR   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS_ADDR = 4'h4;
    localparam logic [1:0]            RESP_OKAY       = 2'b00;

    typedef logic [7:0]  ifmap_t;
    typedef logic [15:0] ipsum_t;

    // Rows fed with ifmap words for a layer
    function automatic int ifmap_active_rows(input layer_type_e layer_type, input int num_rows);
        case (layer_type)
            DEPTHWISE, STANDARD: return (num_rows / 3) * 3;  // Whole groups of three rows
            default:             return num_rows;
        endcase
    endfunction

    // Rows fed with ipsum words for a layer
    function automatic int ipsum_active_rows(input layer_type_e layer_type, input int num_rows);
        case (layer_type)
            DEPTHWISE, STANDARD: return num_rows / 3;        // One per row group
            default:             return num_rows;
        endcase
    endfunction

    // Words each ifmap row pops before the layer starts
    function automatic logic [CNT_W-1:0] ifmap_pop_count(input layer_type_e layer_type,
                                                          input int row);
        case (layer_type)
            DEPTHWISE: return CNT_W'(3 * (row / 3 + 1));     // Grows by three per row group
            STANDARD:  return CNT_W'(3);
            default:   return CNT_W'(1);
        endcase
    endfunction

endpackage

/* logic/preheat_top.sv */
//============================================================
// Preheat stage top level
// AXI4-Lite registers, preheat FSM and ifmap/ipsum feeders
//============================================================
`timescale 1ns/100ps

module preheat_top
    import preheat_pkg::*;
#(
    parameter int NUM_ROWS = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // AXI4-Lite slave
    input  logic [AXI_ADDR_W-1:0]  s_awaddr_i,
    input  logic                   s_awvalid_i,
    output logic                   s_awready_o,
    input  logic [AXI_DATA_W-1:0]  s_wdata_i,
    input  logic                   s_wvalid_i,
    output logic                   s_wready_o,
    output logic [1:0]             s_bresp_o,
    output logic                   s_bvalid_o,
    input  logic                   s_bready_i,
    input  logic [AXI_ADDR_W-1:0]  s_araddr_i,
    input  logic                   s_arvalid_i,
    output logic                   s_arready_o,
    output logic [AXI_DATA_W-1:0]  s_rdata_o,
    output logic [1:0]             s_rresp_o,
    output logic                   s_rvalid_o,
    input  logic                   s_rready_i,
    // Ifmap rows
    input  ifmap_t [NUM_ROWS-1:0]  ifmap_data_i,
    input  logic   [NUM_ROWS-1:0]  ifmap_valid_i,
    output logic   [NUM_ROWS-1:0]  ifmap_pop_o,
    output ifmap_t [NUM_ROWS-1:0]  ifmap_pe_data_o,
    output logic   [NUM_ROWS-1:0]  ifmap_pe_valid_o,
    // Ipsum rows
    input  ipsum_t [NUM_ROWS-1:0]  ipsum_data_i,
    input  logic   [NUM_ROWS-1:0]  ipsum_valid_i,
    output logic   [NUM_ROWS-1:0]  ipsum_pop_o,
    output ipsum_t [NUM_ROWS-1:0]  ipsum_pe_data_o,
    output logic   [NUM_ROWS-1:0]  ipsum_pe_valid_o,
    output logic                   preheat_done_o
);

    logic        start_pulse;
    layer_type_e layer_type;
    logic        busy;

    preheat_cmd_if #(.NUM_ROWS(NUM_ROWS)) ifmap_cmd ();
    preheat_cmd_if #(.NUM_ROWS(NUM_ROWS)) ipsum_cmd ();

    preheat_axil_regs i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .start_o      (start_pulse),
        .layer_type_o (layer_type),
        .busy_i       (busy),
        .done_pulse_i (preheat_done_o)            // Done pulse doubles as status set
    );

    preheat_ctrl #(.NUM_ROWS(NUM_ROWS)) i_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_pulse),
        .layer_type_i   (layer_type),
        .ifmap_cmd      (ifmap_cmd.ctrl),
        .ipsum_cmd      (ipsum_cmd.ctrl),
        .busy_o         (busy),
        .preheat_done_o (preheat_done_o)
    );

    row_feeder #(.NUM_ROWS(NUM_ROWS), .data_t(ifmap_t)) i_ifmap_feeder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (ifmap_cmd.feeder),
        .fifo_data_i  (ifmap_data_i),
        .fifo_valid_i (ifmap_valid_i),
        .fifo_pop_o   (ifmap_pop_o),
        .pe_data_o    (ifmap_pe_data_o),
        .pe_valid_o   (ifmap_pe_valid_o)
    );

    row_feeder #(.NUM_ROWS(NUM_ROWS), .data_t(ipsum_t)) i_ipsum_feeder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (ipsum_cmd.feeder),
        .fifo_data_i  (ipsum_data_i),
        .fifo_valid_i (ipsum_valid_i),
        .fifo_pop_o   (ipsum_pop_o),
        .pe_data_o    (ipsum_pe_data_o),
        .pe_valid_o   (ipsum_pe_valid_o)
    );

endmodule

/* logic/row_feeder.sv */
//============================================================
// Row feeder bank
// Pops each row FIFO a loaded number of times into its PE row
//============================================================
`timescale 1ns/100ps

module row_feeder
    import preheat_pkg::*;
#(
    parameter int  NUM_ROWS = 32,
    parameter type data_t   = ifmap_t
) (
    input  logic                       clk,
    input  logic                       rst_n,
    preheat_cmd_if.feeder              cmd,
    input  data_t [NUM_ROWS-1:0]       fifo_data_i,
    input  logic  [NUM_ROWS-1:0]       fifo_valid_i,   // FIFO not empty
    output logic  [NUM_ROWS-1:0]       fifo_pop_o,
    output data_t [NUM_ROWS-1:0]       pe_data_o,
    output logic  [NUM_ROWS-1:0]       pe_valid_o
);

    logic [NUM_ROWS-1:0][CNT_W-1:0] remain_q;          // Pops still owed per row

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row

        // Pop whenever the row owes words and the FIFO has one
        assign fifo_pop_o[r] = (remain_q[r] != '0) && fifo_valid_i[r];
        assign cmd.done[r]   = (remain_q[r] == '0);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                remain_q[r] <= '0;
            end else if (cmd.load) begin
                remain_q[r] <= cmd.need[r] ? cmd.pop_num[r] : '0;
            end else if (fifo_pop_o[r]) begin
                remain_q[r] <= remain_q[r] - 1'b1;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                pe_valid_o[r] <= 1'b0;
            end else begin
                pe_valid_o[r] <= fifo_pop_o[r];         // Word lands one cycle after pop
            end
        end

        always_ff @(posedge clk) begin
            if (fifo_pop_o[r]) begin
                pe_data_o[r] <= fifo_data_i[r];
            end
        end

    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the preheat testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_preheat -f flist.f -o sim_preheat

./obj_dir/sim_preheat 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Preheat testbench reported errors, see sim.log"
    exit 1
fi
echo "Preheat testbench finished without errors"

/* verif/tb_preheat.sv */
//============================================================
// Preheat stage testbench
// Table-driven runs over all layer types with FIFO models,
// an AXI4-Lite driver and per-row pop scoreboards
//============================================================
`timescale 1ns/100ps

module tb_preheat;
    import preheat_pkg::*;

    localparam int NR             = 8;
    localparam int NUM_TESTS      = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + 100;

    typedef struct packed {
        layer_type_e layer;
        logic        rand_valid;   // Valid pattern from xorshift
        logic        restart;      // Second start while busy
        int          ifmap_total;  // Expected ifmap pops over all rows
        int          ipsum_total;  // Expected ipsum pops over all rows
    } test_entry_t;

    logic               clk;
    logic               rst_n;
    logic [3:0]         s_awaddr;
    logic               s_awvalid;
    logic               s_awready;
    logic [31:0]        s_wdata;
    logic               s_wvalid;
    logic               s_wready;
    logic [1:0]         s_bresp;
    logic               s_bvalid;
    logic               s_bready;
    logic [3:0]         s_araddr;
    logic               s_arvalid;
    logic               s_arready;
    logic [31:0]        s_rdata;
    logic [1:0]         s_rresp;
    logic               s_rvalid;
    logic               s_rready;
    logic [NR-1:0][7:0]  ifmap_data;
    logic [NR-1:0]       ifmap_valid;
    logic [NR-1:0]       ifmap_pop;
    logic [NR-1:0][7:0]  ifmap_pe_data;
    logic [NR-1:0]       ifmap_pe_valid;
    logic [NR-1:0][15:0] ipsum_data;
    logic [NR-1:0]       ipsum_valid;
    logic [NR-1:0]       ipsum_pop;
    logic [NR-1:0][15:0] ipsum_pe_data;
    logic [NR-1:0]       ipsum_pe_valid;
    logic                preheat_done;

    test_entry_t tests [NUM_TESTS];
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'd90;
    logic        rand_mode = 1'b0;
    layer_type_e cur_layer = POINTWISE;
    int          done_pulses;
    int          ifmap_seq [NR];
    int          ipsum_seq [NR];
    int          ifmap_pops [NR];
    int          ipsum_pops [NR];
    logic        ifmap_exp_vld [NR];
    logic [7:0]  ifmap_exp_word [NR];
    logic        ipsum_exp_vld [NR];
    logic [15:0] ipsum_exp_word [NR];

    preheat_top #(.NUM_ROWS(NR)) i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_awaddr_i       (s_awaddr),
        .s_awvalid_i      (s_awvalid),
        .s_awready_o      (s_awready),
        .s_wdata_i        (s_wdata),
        .s_wvalid_i       (s_wvalid),
        .s_wready_o       (s_wready),
        .s_bresp_o        (s_bresp),
        .s_bvalid_o       (s_bvalid),
        .s_bready_i       (s_bready),
        .s_araddr_i       (s_araddr),
        .s_arvalid_i      (s_arvalid),
        .s_arready_o      (s_arready),
        .s_rdata_o        (s_rdata),
        .s_rresp_o        (s_rresp),
        .s_rvalid_o       (s_rvalid),
        .s_rready_i       (s_rready),
        .ifmap_data_i     (ifmap_data),
        .ifmap_valid_i    (ifmap_valid),
        .ifmap_pop_o      (ifmap_pop),
        .ifmap_pe_data_o  (ifmap_pe_data),
        .ifmap_pe_valid_o (ifmap_pe_valid),
        .ipsum_data_i     (ipsum_data),
        .ipsum_valid_i    (ipsum_valid),
        .ipsum_pop_o      (ipsum_pop),
        .ipsum_pe_data_o  (ipsum_pe_data),
        .ipsum_pe_valid_o (ipsum_pe_valid),
        .preheat_done_o   (preheat_done)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                     // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, preheat run never completed", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //============================================================
    // Reference rules and helpers
    //============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // FIFO words carry row in the high half, sequence in the low half
    function automatic logic [7:0] ifmap_word(input int row, input int seq);
        return {row[3:0], seq[3:0]};
    endfunction

    function automatic logic [15:0] ipsum_word(input int row, input int seq);
        return {row[7:0], seq[7:0]};
    endfunction

    function automatic int expect_ifmap_pops(input layer_type_e lt, input int row);
        int groups;
        groups = (NR / 3) * 3;                 // Rows in whole groups of three
        case (lt)
            DEPTHWISE: return (row < groups) ? 3 * (row / 3 + 1) : 0;
            STANDARD:  return (row < groups) ? 3 : 0;
            default:   return 1;
        endcase
    endfunction

    function automatic int expect_ipsum_pops(input layer_type_e lt, input int row);
        case (lt)
            DEPTHWISE, STANDARD: return (row < NR / 3) ? 1 : 0;
            default:             return 1;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL time=%0t %s expected=%0h got=%0h", $time, name, exp, got);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic aw_pend;
        logic w_pend;
        logic aw_fire;
        logic w_fire;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        @(negedge clk);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wvalid  = 1'b1;
        while (aw_pend || w_pend) begin
            aw_fire = s_awvalid && s_awready;  // Handshake at the coming edge
            w_fire  = s_wvalid && s_wready;
            @(negedge clk);
            if (aw_fire) begin
                s_awvalid = 1'b0;
                aw_pend   = 1'b0;
            end
            if (w_fire) begin
                s_wvalid = 1'b0;
                w_pend   = 1'b0;
            end
        end
        while (!s_bvalid) @(negedge clk);
        check_value("s_bresp_o", 32'd0, {30'd0, s_bresp});
        @(negedge clk);
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        logic ar_fire;
        ar_fire = 1'b0;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        while (!ar_fire) begin
            ar_fire = s_arready;
            @(negedge clk);
        end
        s_arvalid = 1'b0;
        while (!s_rvalid) @(negedge clk);
        data = s_rdata;
        check_value("s_rresp_o", 32'd0, {30'd0, s_rresp});
        @(negedge clk);
    endtask

    //============================================================
    // FIFO model and output scoreboard
    //============================================================
    initial begin : fifo_model
        logic finished;
        for (int r = 0; r < NR; r++) begin
            ifmap_seq[r]     = 0;
            ipsum_seq[r]     = 0;
            ifmap_exp_vld[r] = 1'b0;
            ipsum_exp_vld[r] = 1'b0;
        end
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            for (int r = 0; r < NR; r++) begin
                check_value($sformatf("ifmap_pe_valid_o[%0d]", r),
                            32'(ifmap_exp_vld[r]), 32'(ifmap_pe_valid[r]));
                check_value($sformatf("ipsum_pe_valid_o[%0d]", r),
                            32'(ipsum_exp_vld[r]), 32'(ipsum_pe_valid[r]));
                if (ifmap_exp_vld[r]) begin
                    check_value($sformatf("ifmap_pe_data_o[%0d]", r),
                                32'(ifmap_exp_word[r]), 32'(ifmap_pe_data[r]));
                end
                if (ipsum_exp_vld[r]) begin
                    check_value($sformatf("ipsum_pe_data_o[%0d]", r),
                                32'(ipsum_exp_word[r]), 32'(ipsum_pe_data[r]));
                end
                ifmap_data[r] = ifmap_word(r, ifmap_seq[r]);
                ipsum_data[r] = ipsum_word(r, ipsum_seq[r]);
            end
            rng         = xorshift32(rng);
            ifmap_valid = rand_mode ? rng[7:0] : '1;
            ipsum_valid = rand_mode ? rng[15:8] : '1;
            #5;                                // Pop strobes settled mid low phase
            for (int r = 0; r < NR; r++) begin
                assert (!(ifmap_pop[r] && !ifmap_valid[r])) else begin
                    other_errs++;
                    $display("Time %0t: ifmap row %0d popped an empty FIFO", $time, r);
                end
                assert (!(ipsum_pop[r] && !ipsum_valid[r])) else begin
                    other_errs++;
                    $display("Time %0t: ipsum row %0d popped an empty FIFO", $time, r);
                end
                ifmap_exp_vld[r] = ifmap_pop[r];
                ipsum_exp_vld[r] = ipsum_pop[r];
                if (ifmap_pop[r]) begin
                    ifmap_exp_word[r] = ifmap_data[r];
                    ifmap_pops[r]++;
                    ifmap_seq[r]++;
                end
                if (ipsum_pop[r]) begin
                    ipsum_exp_word[r] = ipsum_data[r];
                    ipsum_pops[r]++;
                    ipsum_seq[r]++;
                end
            end
            if (preheat_done) begin
                done_pulses++;
                finished = 1'b1;
                for (int r = 0; r < NR; r++) begin
                    if (ifmap_pops[r] != expect_ifmap_pops(cur_layer, r) ||
                        ipsum_pops[r] != expect_ipsum_pops(cur_layer, r)) begin
                        finished = 1'b0;
                    end
                end
                assert (finished) else begin
                    other_errs++;
                    $display("Time %0t: preheat_done_o rose before every row finished popping",
                             $time);
                end
            end
        end
    end

    //============================================================
    // Main sequence
    //============================================================
    initial begin : main_seq
        test_entry_t entry;
        logic [31:0] rd_val;
        int          ifmap_total;
        int          ipsum_total;
        tests[0] = '{POINTWISE, 1'b0, 1'b0, 8, 8};
        tests[1] = '{DEPTHWISE, 1'b0, 1'b1, 27, 2};
        tests[2] = '{STANDARD,  1'b1, 1'b0, 18, 2};
        tests[3] = '{LINEAR,    1'b1, 1'b0, 8, 8};
        rst_n       = 1'b0;
        s_awaddr    = '0;
        s_awvalid   = 1'b0;
        s_wdata     = '0;
        s_wvalid    = 1'b0;
        s_bready    = 1'b1;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b1;
        ifmap_data  = '0;
        ifmap_valid = '0;
        ipsum_data  = '0;
        ipsum_valid = '0;
        done_pulses = 0;
        for (int r = 0; r < NR; r++) begin
            ifmap_pops[r] = 0;
            ipsum_pops[r] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Quiet outputs and cleared registers out of reset
        check_value("ifmap_pop_o", 32'd0, 32'(ifmap_pop));
        check_value("ipsum_pop_o", 32'd0, 32'(ipsum_pop));
        check_value("preheat_done_o", 32'd0, 32'(preheat_done));
        check_value("s_bvalid_o", 32'd0, 32'(s_bvalid));
        check_value("s_rvalid_o", 32'd0, 32'(s_rvalid));
        read_reg(REG_STATUS_ADDR, rd_val);
        check_value("STATUS after reset", 32'd0, rd_val);
        read_reg(REG_CTRL_ADDR, rd_val);
        check_value("CTRL after reset", 32'd0, rd_val);

        for (int t = 0; t < NUM_TESTS; t++) begin
            entry = tests[t];
            @(negedge clk);
            #2;                                // Clear between FIFO model updates
            cur_layer   = entry.layer;
            rand_mode   = entry.rand_valid;
            done_pulses = 0;
            for (int r = 0; r < NR; r++) begin
                ifmap_pops[r] = 0;
                ipsum_pops[r] = 0;
            end
            write_reg(REG_CTRL_ADDR, {29'd0, entry.layer, 1'b1});
            if (entry.restart) begin
                write_reg(REG_CTRL_ADDR, {29'd0, entry.layer, 1'b1});  // Lands in WAIT
            end
            read_reg(REG_STATUS_ADDR, rd_val);
            check_value("STATUS during run", 32'h1, rd_val);
            while (preheat_done !== 1'b1) @(negedge clk);
            repeat (3) @(negedge clk);

            ifmap_total = 0;
            ipsum_total = 0;
            for (int r = 0; r < NR; r++) begin
                check_value($sformatf("ifmap_pop_o[%0d] count", r),
                            expect_ifmap_pops(entry.layer, r), ifmap_pops[r]);
                check_value($sformatf("ipsum_pop_o[%0d] count", r),
                            expect_ipsum_pops(entry.layer, r), ipsum_pops[r]);
                ifmap_total += ifmap_pops[r];
                ipsum_total += ipsum_pops[r];
            end
            check_value("ifmap_pop_o total", entry.ifmap_total, ifmap_total);
            check_value("ipsum_pop_o total", entry.ipsum_total, ipsum_total);
            check_value("preheat_done_o pulses", 32'd1, done_pulses);
            read_reg(REG_STATUS_ADDR, rd_val);
            check_value("STATUS after run", 32'h2, rd_val);
            read_reg(REG_CTRL_ADDR, rd_val);
            check_value("CTRL readback", {29'd0, entry.layer, 1'b0}, rd_val);
        end

        $display("Checks complete: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
